// File: source/backend_pkg.sv
package backend_pkg;

    // Default widths, overridden through the top level parameters
    localparam int DEF_ADDR_W = 8;
    localparam int DEF_DATA_W = 32;

    // Sixteen general-purpose registers
    localparam int GP_IDX_W = 4;

    typedef logic [GP_IDX_W-1:0] gp_idx_t;

    typedef enum logic [3:0] {
        OPC_NOP  = 4'h0,
        OPC_ALU  = 4'h1,
        OPC_LD   = 4'h2,
        OPC_ST   = 4'h3,
        OPC_LDST = 4'h4
    } opc_t;

    // Any opcode that uses a memory port
    function automatic logic is_mem_op(opc_t opc);
        return (opc == OPC_LD) || (opc == OPC_ST) || (opc == OPC_LDST);
    endfunction

    // Opcodes that take their writeback value from memory
    function automatic logic reads_mem(opc_t opc);
        return (opc == OPC_LD) || (opc == OPC_LDST);
    endfunction

    // Opcodes that store result into memory
    function automatic logic writes_mem(opc_t opc);
        return (opc == OPC_ST) || (opc == OPC_LDST);
    endfunction

endpackage

// File: source/stage_if.sv
`timescale 1ns/10ps

// Registered instruction bundle passed from MA to MO
interface stage_if #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
);

    logic [ADDR_W-1:0]       pc;
    backend_pkg::opc_t       opc;
    backend_pkg::gp_idx_t    tgt_gp;
    logic                    tgt_gp_we;
    logic [DATA_W-1:0]       result;
    logic                    trap_pending;

    modport ma (
        output pc,
        output opc,
        output tgt_gp,
        output tgt_gp_we,
        output result,
        output trap_pending
    );

    modport mo (
        input pc,
        input opc,
        input tgt_gp,
        input tgt_gp_we,
        input result,
        input trap_pending
    );

endinterface

// File: source/dmem_if.sv
`timescale 1ns/10ps

// Shared connection of MA, MO and the dual-port data memory
interface dmem_if #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
);

    // Port used by MO this cycle, MA loads the other one
    logic                 mem_mp;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    wdata;
    logic                 we;
    logic [DATA_W-1:0]    rdata;

    modport ma (
        output mem_mp,
        output addr
    );

    modport mo (
        input  mem_mp,
        input  rdata,
        output wdata,
        output we
    );

    modport mem (
        input  mem_mp,
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// File: source/ma_stage.sv
`timescale 1ns/10ps

module ma_stage #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
) (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  logic                 stall,
    input  logic [ADDR_W-1:0]    pc,
    input  backend_pkg::opc_t    opc,
    input  backend_pkg::gp_idx_t tgt_gp,
    input  logic                 tgt_gp_we,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [DATA_W-1:0]    result,
    input  logic                 trap_pending,
    stage_if.ma                  stg,
    dmem_if.ma                   dmem
);

    logic [ADDR_W-1:0]    r_pc;
    backend_pkg::opc_t    r_opc;
    backend_pkg::gp_idx_t r_tgt_gp;
    logic                 r_tgt_gp_we;
    logic [DATA_W-1:0]    r_result;
    logic                 r_trap_pending;
    logic                 r_mem_mp;
    logic                 r_prev_stall;
    logic                 w_flip_mp;

    // A held memory operation flips the port only on its first cycle
    assign w_flip_mp = backend_pkg::is_mem_op(opc) && (!stall || !r_prev_stall);

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            r_pc           <= '0;
            r_opc          <= backend_pkg::OPC_NOP;
            r_tgt_gp       <= '0;
            r_tgt_gp_we    <= 1'b0;
            r_result       <= '0;
            r_trap_pending <= 1'b0;
            r_prev_stall   <= 1'b0;
        end else begin
            r_pc           <= pc;
            r_opc          <= opc;
            r_tgt_gp       <= tgt_gp;
            r_tgt_gp_we    <= tgt_gp_we;
            r_result       <= result;
            r_trap_pending <= trap_pending;
            r_prev_stall   <= stall;
        end
    end

    // Starts at 0 so the first address goes into port 1
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            r_mem_mp <= 1'b0;
        end else if (w_flip_mp) begin
            r_mem_mp <= ~r_mem_mp;
        end
    end

    assign stg.pc           = r_pc;
    assign stg.opc          = r_opc;
    assign stg.tgt_gp       = r_tgt_gp;
    assign stg.tgt_gp_we    = r_tgt_gp_we;
    assign stg.result       = r_result;
    assign stg.trap_pending = r_trap_pending;

    // The memory captures addr itself into the port MO is not using
    assign dmem.mem_mp = r_mem_mp;
    assign dmem.addr   = addr;

endmodule

// File: source/data_mem.sv
`timescale 1ns/10ps

module data_mem #(
    parameter int ADDR_W    = 8,
    parameter int DATA_W    = 32,
    parameter int MEM_DEPTH = 2 ** ADDR_W
) (
    input  logic iw_clk,
    input  logic iw_rst,
    dmem_if.mem  dmem
);

    logic [ADDR_W-1:0] r_addr [2];
    logic [DATA_W-1:0] r_mem [MEM_DEPTH];
    logic [ADDR_W-1:0] w_port_addr;

    // MA always fills the port that MO is not working on
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            r_addr[0] <= '0;
            r_addr[1] <= '0;
        end else if (dmem.mem_mp) begin
            r_addr[0] <= dmem.addr;
        end else begin
            r_addr[1] <= dmem.addr;
        end
    end

    assign w_port_addr = dmem.mem_mp ? r_addr[1] : r_addr[0];

    // Both ports share one storage array
    always_ff @(posedge iw_clk) begin
        if (dmem.we) begin
            r_mem[w_port_addr] <= dmem.wdata;
        end
    end

    // Read is combinational so a swap sees the old word before the write
    assign dmem.rdata = r_mem[w_port_addr];

endmodule

// File: source/mo_stage.sv
`timescale 1ns/10ps

module mo_stage #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
) (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    stage_if.mo                  stg,
    dmem_if.mo                   dmem,
    output logic                 wb_we,
    output backend_pkg::gp_idx_t wb_idx,
    output logic [DATA_W-1:0]    wb_data,
    output logic                 retire_valid,
    output logic [ADDR_W-1:0]    retire_pc,
    output backend_pkg::opc_t    retire_opc
);

    logic                 w_store;
    logic                 w_load;
    logic                 r_retire_valid;
    logic [ADDR_W-1:0]    r_retire_pc;
    backend_pkg::opc_t    r_retire_opc;

    assign w_store = backend_pkg::writes_mem(stg.opc);
    assign w_load  = backend_pkg::reads_mem(stg.opc);

    // A pending trap squashes the store but the operation still retires
    assign dmem.we    = w_store && !stg.trap_pending;
    assign dmem.wdata = stg.result;

    // Writeback is committed by the register file at the next edge
    always_comb begin
        wb_idx = stg.tgt_gp;
        wb_we  = stg.tgt_gp_we && !stg.trap_pending;
        if (w_load) begin
            wb_data = dmem.rdata;
        end else begin
            wb_data = stg.result;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            r_retire_valid <= 1'b0;
            r_retire_pc    <= '0;
            r_retire_opc   <= backend_pkg::OPC_NOP;
        end else begin
            r_retire_valid <= (stg.opc != backend_pkg::OPC_NOP);
            r_retire_pc    <= stg.pc;
            r_retire_opc   <= stg.opc;
        end
    end

    assign retire_valid = r_retire_valid;
    assign retire_pc    = r_retire_pc;
    assign retire_opc   = r_retire_opc;

endmodule

// File: source/gp_regfile.sv
`timescale 1ns/10ps

module gp_regfile #(
    parameter int DATA_W = 32
) (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  logic                 wb_we,
    input  backend_pkg::gp_idx_t wb_idx,
    input  logic [DATA_W-1:0]    wb_data,
    input  backend_pkg::gp_idx_t rd_idx,
    output logic [DATA_W-1:0]    rd_data
);

    localparam int NUM_REGS = 2 ** backend_pkg::GP_IDX_W;

    logic [DATA_W-1:0] r_gp [NUM_REGS];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                r_gp[i] <= '0;
            end
        end else if (wb_we) begin
            r_gp[wb_idx] <= wb_data;
        end
    end

    // Operand read for the execute stage, no bypass from the write port
    assign rd_data = r_gp[rd_idx];

endmodule

// File: source/mem_back_end.sv
`timescale 1ns/10ps

module mem_back_end #(
    parameter int ADDR_W    = backend_pkg::DEF_ADDR_W,
    parameter int DATA_W    = backend_pkg::DEF_DATA_W,
    parameter int MEM_DEPTH = 2 ** ADDR_W
) (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  logic                 stall,
    input  logic [ADDR_W-1:0]    pc,
    input  backend_pkg::opc_t    opc,
    input  backend_pkg::gp_idx_t tgt_gp,
    input  logic                 tgt_gp_we,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [DATA_W-1:0]    result,
    input  logic                 trap_pending,
    input  backend_pkg::gp_idx_t rd_idx,
    output logic [DATA_W-1:0]    rd_data,
    output logic                 retire_valid,
    output logic [ADDR_W-1:0]    retire_pc,
    output backend_pkg::opc_t    retire_opc
);

    logic                 wb_we;
    backend_pkg::gp_idx_t wb_idx;
    logic [DATA_W-1:0]    wb_data;

    stage_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_stage_if ();
    dmem_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_dmem_if ();

    ma_stage #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_ma_stage (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .pc           (pc),
        .opc          (opc),
        .tgt_gp       (tgt_gp),
        .tgt_gp_we    (tgt_gp_we),
        .addr         (addr),
        .result       (result),
        .trap_pending (trap_pending),
        .stg          (u_stage_if.ma),
        .dmem         (u_dmem_if.ma)
    );

    data_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) u_data_mem (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .dmem   (u_dmem_if.mem)
    );

    mo_stage #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mo_stage (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stg          (u_stage_if.mo),
        .dmem         (u_dmem_if.mo),
        .wb_we        (wb_we),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_opc   (retire_opc)
    );

    gp_regfile #(.DATA_W(DATA_W)) u_gp_regfile (
        .iw_clk  (iw_clk),
        .iw_rst  (iw_rst),
        .wb_we   (wb_we),
        .wb_idx  (wb_idx),
        .wb_data (wb_data),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

endmodule

// File: dv/tb_mem_back_end.sv
`timescale 1ns/10ps

module tb_mem_back_end;

    localparam int ADDR_W         = backend_pkg::DEF_ADDR_W;
    localparam int DATA_W         = backend_pkg::DEF_DATA_W;
    localparam int NUM_REGS       = 2 ** backend_pkg::GP_IDX_W;
    localparam int RETIRE_TIMEOUT = 20;

    logic                 iw_clk;
    logic                 iw_rst;
    logic                 stall;
    logic [ADDR_W-1:0]    pc;
    backend_pkg::opc_t    opc;
    backend_pkg::gp_idx_t tgt_gp;
    logic                 tgt_gp_we;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    result;
    logic                 trap_pending;
    backend_pkg::gp_idx_t rd_idx;
    logic [DATA_W-1:0]    rd_data;
    logic                 retire_valid;
    logic [ADDR_W-1:0]    retire_pc;
    backend_pkg::opc_t    retire_opc;

    // Reference model of the data memory and the register file
    logic [DATA_W-1:0]    ref_mem [2 ** ADDR_W];
    logic [DATA_W-1:0]    ref_gp [NUM_REGS];
    integer               seed;
    logic [ADDR_W-1:0]    next_pc;
    logic [ADDR_W-1:0]    last_pc;

    mem_back_end #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mem_back_end (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .pc           (pc),
        .opc          (opc),
        .tgt_gp       (tgt_gp),
        .tgt_gp_we    (tgt_gp_we),
        .addr         (addr),
        .result       (result),
        .trap_pending (trap_pending),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_opc   (retire_opc)
    );

    initial begin
        iw_clk = 1'b0;
        forever #4 iw_clk = ~iw_clk;
    end

    function automatic logic [DATA_W-1:0] rand_word();
        logic [31:0] w;
        w = $random(seed);
        return w;
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        logic [31:0] w;
        w = $random(seed);
        return w[ADDR_W-1:0];
    endfunction

    task automatic check_val(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_idle();
        stall        = 1'b0;
        opc          = backend_pkg::OPC_NOP;
        tgt_gp       = '0;
        tgt_gp_we    = 1'b0;
        addr         = '0;
        result       = '0;
        trap_pending = 1'b0;
    endtask

    // Presents one instruction and repeats it under stall for hold extra cycles
    task automatic issue(input backend_pkg::opc_t op, input backend_pkg::gp_idx_t tgt,
                         input logic we, input logic [ADDR_W-1:0] a,
                         input logic [DATA_W-1:0] res, input logic trap, input int hold);
        int                k;
        logic [DATA_W-1:0] wb;
        for (k = 0; k <= hold; k++) begin
            @(negedge iw_clk);
            pc           = next_pc;
            opc          = op;
            tgt_gp       = tgt;
            tgt_gp_we    = we;
            addr         = a;
            result       = res;
            trap_pending = trap;
            stall        = (k < hold);
        end
        last_pc = next_pc;
        next_pc = next_pc + 1'b1;
        // A pending trap leaves both memory and registers untouched
        if (!trap) begin
            if (op == backend_pkg::OPC_LD || op == backend_pkg::OPC_LDST) begin
                wb = ref_mem[a];
            end else begin
                wb = res;
            end
            if (we) begin
                ref_gp[tgt] = wb;
            end
            if (op == backend_pkg::OPC_ST || op == backend_pkg::OPC_LDST) begin
                ref_mem[a] = res;
            end
        end
    endtask

    task automatic wait_retire(input logic [ADDR_W-1:0] exp_pc,
                               input backend_pkg::opc_t exp_opc);
        int   n;
        logic found;
        found = 1'b0;
        for (n = 0; n < RETIRE_TIMEOUT && !found; n++) begin
            @(negedge iw_clk);
            drive_idle();
            if (retire_valid && retire_pc == exp_pc) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Timed out waiting for the instruction at pc %h to retire", exp_pc);
            $display("TESTS FAILED");
            $fatal(1, "retire timeout");
        end
        check_val("retire_opc", DATA_W'(retire_opc), DATA_W'(exp_opc));
    endtask

    task automatic read_reg(input backend_pkg::gp_idx_t idx, output logic [DATA_W-1:0] val);
        @(negedge iw_clk);
        rd_idx = idx;
        #1;
        val = rd_data;
    endtask

    task automatic check_all_regs();
        logic [DATA_W-1:0] val;
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(4'(i), val);
            check_val($sformatf("gp[%0d]", i), val, ref_gp[i]);
        end
    endtask

    task automatic test_reset();
        logic [DATA_W-1:0] val;
        check_val("retire_valid after reset", DATA_W'(retire_valid), '0);
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(4'(i), val);
            check_val($sformatf("gp[%0d] after reset", i), val, '0);
        end
    endtask

    task automatic test_alu_writeback();
        for (int i = 0; i < NUM_REGS; i++) begin
            issue(backend_pkg::OPC_ALU, 4'(i), (i % 3) != 0, rand_addr(), rand_word(), 1'b0, 0);
        end
        // Second pass rewrites only the odd steps
        for (int i = 0; i < 8; i++) begin
            issue(backend_pkg::OPC_ALU, 4'(2 * i), i[0], rand_addr(), rand_word(), 1'b0, 0);
        end
        wait_retire(last_pc, backend_pkg::OPC_ALU);
        check_all_regs();
    endtask

    task automatic test_store_load();
        logic [ADDR_W-1:0] addrs [8];
        logic [ADDR_W-1:0] a;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = rand_addr();
            issue(backend_pkg::OPC_ST, '0, 1'b0, addrs[i], rand_word(), 1'b0, 0);
        end
        for (int i = 0; i < 8; i++) begin
            issue(backend_pkg::OPC_LD, 4'(i + 1), 1'b1, addrs[i], rand_word(), 1'b0, 0);
            if (i % 3 == 1) begin
                issue(backend_pkg::OPC_ALU, 4'd12, 1'b1, rand_addr(), rand_word(), 1'b0, 0);
            end
        end
        // Load right behind a store to the same word
        a = rand_addr();
        issue(backend_pkg::OPC_ST, '0, 1'b0, a, rand_word(), 1'b0, 0);
        issue(backend_pkg::OPC_LD, 4'd13, 1'b1, a, rand_word(), 1'b0, 0);
        wait_retire(last_pc, backend_pkg::OPC_LD);
        check_all_regs();
    endtask

    task automatic test_swap();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] old_word;
        logic [DATA_W-1:0] new_word;
        logic [DATA_W-1:0] val;
        a        = rand_addr();
        old_word = rand_word();
        new_word = rand_word();
        issue(backend_pkg::OPC_ST, '0, 1'b0, a, old_word, 1'b0, 0);
        issue(backend_pkg::OPC_LDST, 4'd5, 1'b1, a, new_word, 1'b0, 0);
        issue(backend_pkg::OPC_LD, 4'd6, 1'b1, a, rand_word(), 1'b0, 0);
        wait_retire(last_pc, backend_pkg::OPC_LD);
        read_reg(4'd5, val);
        check_val("swap old word", val, old_word);
        read_reg(4'd6, val);
        check_val("load after swap", val, new_word);
    endtask

    task automatic test_stall();
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] d_b;
        logic [DATA_W-1:0] val;
        a   = rand_addr();
        b   = a + 1'b1;
        d   = rand_word();
        d_b = rand_word();
        // The held store must leave the word of the previous memory operation alone
        issue(backend_pkg::OPC_ST, '0, 1'b0, b, d_b, 1'b0, 0);
        issue(backend_pkg::OPC_ST, '0, 1'b0, a, d, 1'b0, 3);
        issue(backend_pkg::OPC_ALU, 4'd8, 1'b1, rand_addr(), rand_word(), 1'b0, 0);
        issue(backend_pkg::OPC_LD, 4'd7, 1'b1, a, rand_word(), 1'b0, 3);
        issue(backend_pkg::OPC_LD, 4'd15, 1'b1, b, rand_word(), 1'b0, 0);
        issue(backend_pkg::OPC_ALU, 4'd14, 1'b1, rand_addr(), rand_word(), 1'b0, 0);
        wait_retire(last_pc, backend_pkg::OPC_ALU);
        read_reg(4'd7, val);
        check_val("load after stalled store", val, d);
        read_reg(4'd15, val);
        check_val("word next to stalled store", val, d_b);
        check_all_regs();
    endtask

    task automatic test_trap();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d1;
        logic [DATA_W-1:0] v1;
        logic [DATA_W-1:0] val;
        a  = rand_addr();
        d1 = rand_word();
        v1 = rand_word();
        issue(backend_pkg::OPC_ST, '0, 1'b0, a, d1, 1'b0, 0);
        issue(backend_pkg::OPC_ALU, 4'd9, 1'b1, rand_addr(), v1, 1'b0, 0);
        wait_retire(last_pc, backend_pkg::OPC_ALU);
        issue(backend_pkg::OPC_ST, '0, 1'b0, a, rand_word(), 1'b1, 0);
        wait_retire(last_pc, backend_pkg::OPC_ST);
        issue(backend_pkg::OPC_ALU, 4'd9, 1'b1, rand_addr(), rand_word(), 1'b1, 0);
        wait_retire(last_pc, backend_pkg::OPC_ALU);
        issue(backend_pkg::OPC_LD, 4'd10, 1'b1, a, rand_word(), 1'b1, 0);
        wait_retire(last_pc, backend_pkg::OPC_LD);
        issue(backend_pkg::OPC_LD, 4'd11, 1'b1, a, rand_word(), 1'b0, 0);
        wait_retire(last_pc, backend_pkg::OPC_LD);
        read_reg(4'd11, val);
        check_val("memory after trapped store", val, d1);
        read_reg(4'd9, val);
        check_val("gp[9] after trapped write", val, v1);
        check_all_regs();
    endtask

    initial begin
        seed    = 59717;
        next_pc = 8'h10;
        last_pc = '0;
        iw_rst  = 1'b1;
        pc      = '0;
        rd_idx  = '0;
        drive_idle();
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_gp[i] = '0;
        end
        repeat (3) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;

        test_reset();
        test_alu_writeback();
        test_store_load();
        test_swap();
        test_stall();
        test_trap();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: flist.f
source/backend_pkg.sv
source/stage_if.sv
source/dmem_if.sv
source/ma_stage.sv
source/data_mem.sv
source/mo_stage.sv
source/gp_regfile.sv
source/mem_back_end.sv
dv/tb_mem_back_end.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_mem_back_end --Mdir obj_dir -o sim_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
